/* cpuPkg.sv */
// Shared widths, types, opcodes and instruction field positions, imported by every core module
`default_nettype none

package cpuPkg;

	localparam int WORD_W = 32;
	localparam int REG_IDX_W = 5;
	localparam int OPC_W = 7;
	localparam int NUM_REGS = 2 ** REG_IDX_W;

	typedef logic [WORD_W-1:0] wordT;
	typedef logic [REG_IDX_W-1:0] regIdxT;

	typedef enum logic [OPC_W-1:0] {
		OP_ADD = 7'h00,
		OP_SUB = 7'h01,
		OP_LDW = 7'h11,
		OP_STW = 7'h13,
		OP_MOVI = 7'h15,
		OP_BEQ = 7'h30,
		OP_JUMP = 7'h31,
		OP_BZ = 7'h34,
		OP_NOP = 7'h7F
	} opcodeT;

	localparam wordT RESET_PC = 32'h0000_1000;
	localparam wordT NOP_INST = 32'hFFFF_FFFF;

	// Instruction fields
	localparam int OPC_HI = 31;
	localparam int OPC_LO = 25;
	localparam int RD_HI = 24;
	localparam int RD_LO = 20;
	localparam int RS1_HI = 19;
	localparam int RS1_LO = 15;
	localparam int RS2_HI = 14;
	localparam int RS2_LO = 10;
	localparam int IMM15_HI = 14;
	localparam int IMM20_HI = 19;

	// Opcodes that end with a register write
	function automatic logic opWritesReg(input opcodeT op);
		return (op == OP_ADD) || (op == OP_SUB) || (op == OP_MOVI) || (op == OP_LDW);
	endfunction

	// Opcodes that use the data port
	function automatic logic opIsMem(input opcodeT op);
		return (op == OP_LDW) || (op == OP_STW);
	endfunction

endpackage

`default_nettype wire

/* fetchUnit.sv */
// Program counter and fetch-to-decode register, advanced by stall and flush from pipeline control
`timescale 1ns/1ps
`default_nettype none

module fetchUnit
	import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic stallFront,
	input  logic flushFront,
	input  wordT branchTarget,
	input  wordT instData,
	output wordT instAddr,
	output wordT decInst,
	output wordT decPc
);

	wordT pc;

	// Instruction memory is read combinationally at the current PC
	assign instAddr = pc;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pc <= RESET_PC;
			decInst <= NOP_INST;
		end
		else if (flushFront)
		begin
			// Redirect and kill the wrong-path fetch
			pc <= branchTarget;
			decInst <= NOP_INST;
		end
		else if (!stallFront)
		begin
			pc <= pc + 32'd4;
			decInst <= instData;
		end
	end

	// PC of the instruction in decode
	always_ff @(posedge clk)
	begin
		if (!stallFront)
			decPc <= pc;
	end

endmodule

`default_nettype wire

/* instructionDecoder.sv */
// Decode stage: field split, immediates, operand selection and the decode-to-execute register
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder
	import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic stallFront,
	input  logic flushFront,
	input  logic stallAll,
	input  wordT decInst,
	input  wordT decPc,
	input  wordT rdData1,
	input  wordT rdData2,
	output opcodeT decOpcode,
	output regIdxT decRs1,
	output regIdxT decRs2,
	output regIdxT decRd,
	output opcodeT exOpcode,
	output regIdxT exDst,
	output wordT exA,
	output wordT exB,
	output wordT exStore,
	output wordT exPc
);

	wordT imm15Ext;
	wordT imm20Ext;
	wordT aNext;
	wordT bNext;

	// Anything not in the opcode list runs as a NOP
	always_comb
	begin
		case (opcodeT'(decInst[OPC_HI:OPC_LO]))
			OP_ADD, OP_SUB, OP_LDW, OP_STW, OP_MOVI, OP_BEQ, OP_JUMP, OP_BZ:
				decOpcode = opcodeT'(decInst[OPC_HI:OPC_LO]);
			default:
				decOpcode = OP_NOP;
		endcase
	end

	assign decRd = decInst[RD_HI:RD_LO];
	assign decRs1 = decInst[RS1_HI:RS1_LO];
	// Second read port carries rd for stores and compares
	assign decRs2 = (decOpcode == OP_STW || decOpcode == OP_BEQ || decOpcode == OP_BZ) ?
		decRd : decInst[RS2_HI:RS2_LO];

	assign imm15Ext = {{(WORD_W-IMM15_HI-1){decInst[IMM15_HI]}}, decInst[IMM15_HI:0]};
	assign imm20Ext = {{(WORD_W-IMM20_HI-1){decInst[IMM20_HI]}}, decInst[IMM20_HI:0]};

	// Operand pair per instruction format
	always_comb
	begin
		aNext = rdData1;
		bNext = rdData2;
		case (decOpcode)
			OP_LDW, OP_STW, OP_BEQ, OP_JUMP:
				bNext = imm15Ext;
			OP_BZ:
				bNext = imm20Ext;
			OP_MOVI:
			begin
				aNext = imm20Ext;
				bNext = '0;
			end
			default:
				bNext = rdData2;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			exOpcode <= OP_NOP;
		else if (flushFront || (stallFront && !stallAll))
			exOpcode <= OP_NOP;    // bubble behind an interlock, or flushed
		else if (!stallAll)
			exOpcode <= decOpcode;
	end

	always_ff @(posedge clk)
	begin
		if (!stallAll)
		begin
			exDst <= decRd;
			exA <= aNext;
			exB <= bNext;
			exStore <= rdData2;
			exPc <= decPc;
		end
	end

endmodule

`default_nettype wire

/* registerFile.sv */
// General register file with two combinational read ports and write-through from writeback
`timescale 1ns/1ps
`default_nettype none

module registerFile
	import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic wbWe,
	input  regIdxT rdAddr1,
	input  regIdxT rdAddr2,
	input  regIdxT wbAddr,
	input  wordT wbData,
	output wordT rdData1,
	output wordT rdData2
);

	wordT regs [NUM_REGS];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end
		else if (wbWe)
			regs[wbAddr] <= wbData;
	end

	// Same-cycle write is visible to decode
	assign rdData1 = (wbWe && wbAddr == rdAddr1) ? wbData : regs[rdAddr1];
	assign rdData2 = (wbWe && wbAddr == rdAddr2) ? wbData : regs[rdAddr2];

endmodule

`default_nettype wire

/* executeUnit.sv */
// Execute stage: add/subtract, branch resolution and the execute-to-memory register
`timescale 1ns/1ps
`default_nettype none

module executeUnit
	import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic stallAll,
	input  opcodeT exOpcode,
	input  regIdxT exDst,
	input  wordT exA,
	input  wordT exB,
	input  wordT exStore,
	input  wordT exPc,
	output logic exWrites,
	output logic branchTaken,
	output wordT branchTarget,
	output wordT memAddrOrResult,
	output wordT memStore,
	output opcodeT memOpcode,
	output regIdxT memDst,
	output logic memWrites
);

	wordT aluResult;

	// Also the load/store address, and MOVI passes with exB at zero
	assign aluResult = (exOpcode == OP_SUB) ? exA - exB : exA + exB;

	assign exWrites = opWritesReg(exOpcode);

	// BEQ compares rd (exStore) with rs1, BZ tests rd alone
	assign branchTaken = (exOpcode == OP_JUMP) ||
		((exOpcode == OP_BEQ) && (exStore == exA)) ||
		((exOpcode == OP_BZ) && (exStore == '0));

	// JUMP is register relative, the others PC relative
	assign branchTarget = ((exOpcode == OP_JUMP) ? exA : exPc) + exB;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			memOpcode <= OP_NOP;
			memWrites <= 1'b0;
		end
		else if (!stallAll)
		begin
			// A taken branch leaves as a bubble
			memOpcode <= branchTaken ? OP_NOP : exOpcode;
			memWrites <= exWrites;
		end
	end

	always_ff @(posedge clk)
	begin
		if (!stallAll)
		begin
			memAddrOrResult <= aluResult;
			memStore <= exStore;
			memDst <= exDst;
		end
	end

endmodule

`default_nettype wire

/* memoryAccess.sv */
// Memory stage: data-port request held until done, and the writeback register
`timescale 1ns/1ps
`default_nettype none

module memoryAccess
	import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	input  logic dataDone,
	input  opcodeT memOpcode,
	input  regIdxT memDst,
	input  wordT memAddrOrResult,
	input  wordT memStore,
	input  wordT dataRdata,
	output logic dataReq,
	output logic dataWe,
	output logic memBusy,
	output logic wbWe,
	output wordT dataAddr,
	output wordT dataWdata,
	output wordT wbData,
	output regIdxT wbAddr
);

	logic isMem;
	logic doneLast;

	assign isMem = opIsMem(memOpcode);

	// Request drops for one cycle after done, even with another access waiting
	assign dataReq = isMem && !doneLast;
	assign dataWe = dataReq && (memOpcode == OP_STW);
	assign dataAddr = memAddrOrResult;
	assign dataWdata = memStore;

	// Holds the whole pipeline until the access completes
	assign memBusy = isMem && !dataDone;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			doneLast <= 1'b0;
			wbWe <= 1'b0;
		end
		else
		begin
			doneLast <= dataDone;
			// One write per instruction, none while waiting
			wbWe <= opWritesReg(memOpcode) && !memBusy;
		end
	end

	always_ff @(posedge clk)
	begin
		wbData <= (memOpcode == OP_LDW) ? dataRdata : memAddrOrResult;
		wbAddr <= memDst;
	end

endmodule

`default_nettype wire

/* pipelineControl.sv */
// Hazard interlock, memory stall and branch flush decisions for the whole pipeline
`timescale 1ns/1ps
`default_nettype none

module pipelineControl
	import cpuPkg::*;
(
	input  opcodeT decOpcode,
	input  regIdxT decRs1,
	input  regIdxT decRs2,
	input  regIdxT decRd,
	input  regIdxT exDst,
	input  regIdxT memDst,
	input  logic exWrites,
	input  logic memWrites,
	input  logic branchTaken,
	input  logic memBusy,
	output logic stallFront,
	output logic flushFront,
	output logic stallAll
);

	logic readsRs1;
	logic readsRs2;
	logic readsRd;
	logic hazard;

	// Sources read in decode, per opcode
	assign readsRs1 = (decOpcode == OP_ADD) || (decOpcode == OP_SUB) ||
		(decOpcode == OP_LDW) || (decOpcode == OP_STW) ||
		(decOpcode == OP_BEQ) || (decOpcode == OP_JUMP);
	assign readsRs2 = (decOpcode == OP_ADD) || (decOpcode == OP_SUB);
	assign readsRd = (decOpcode == OP_STW) || (decOpcode == OP_BEQ) || (decOpcode == OP_BZ);

	// No forwarding, so wait for the producer to reach writeback
	function automatic logic pending(input regIdxT idx, input regIdxT eDst, input logic eWr,
		input regIdxT mDst, input logic mWr);
		return (eWr && eDst == idx) || (mWr && mDst == idx);
	endfunction

	assign hazard = (readsRs1 && pending(decRs1, exDst, exWrites, memDst, memWrites)) ||
		(readsRs2 && pending(decRs2, exDst, exWrites, memDst, memWrites)) ||
		(readsRd && pending(decRd, exDst, exWrites, memDst, memWrites));

	assign stallFront = hazard || memBusy;
	assign stallAll = memBusy;
	// Branch stays in execute until the data port is free
	assign flushFront = branchTaken && !memBusy;

endmodule

`default_nettype wire

/* cpuCore.sv */
// Core top level, wiring the five pipeline stages to the instruction and data ports
`timescale 1ns/1ps
`default_nettype none

module cpuCore
	import cpuPkg::*;
(
	input  logic clk,
	input  logic rst,
	output wordT instAddr,
	input  wordT instData,
	output logic dataReq,
	output logic dataWe,
	output wordT dataAddr,
	output wordT dataWdata,
	input  logic dataDone,
	input  wordT dataRdata
);

	logic stallFront;
	logic flushFront;
	logic stallAll;
	logic branchTaken;
	logic memBusy;
	logic exWrites;
	logic memWrites;
	logic wbWe;
	wordT branchTarget;
	wordT decInst;
	wordT decPc;
	wordT rdData1;
	wordT rdData2;
	wordT exA;
	wordT exB;
	wordT exStore;
	wordT exPc;
	wordT memAddrOrResult;
	wordT memStore;
	wordT wbData;
	opcodeT decOpcode;
	opcodeT exOpcode;
	opcodeT memOpcode;
	regIdxT decRs1;
	regIdxT decRs2;
	regIdxT decRd;
	regIdxT exDst;
	regIdxT memDst;
	regIdxT wbAddr;

	fetchUnit i_fetchUnit (
		.clk(clk), .rst(rst), .stallFront(stallFront), .flushFront(flushFront),
		.branchTarget(branchTarget), .instData(instData), .instAddr(instAddr),
		.decInst(decInst), .decPc(decPc)
	);

	instructionDecoder i_instructionDecoder (
		.clk(clk), .rst(rst), .stallFront(stallFront), .flushFront(flushFront),
		.stallAll(stallAll), .decInst(decInst), .decPc(decPc), .rdData1(rdData1),
		.rdData2(rdData2), .decOpcode(decOpcode), .decRs1(decRs1), .decRs2(decRs2),
		.decRd(decRd), .exOpcode(exOpcode), .exDst(exDst), .exA(exA), .exB(exB),
		.exStore(exStore), .exPc(exPc)
	);

	registerFile i_registerFile (
		.clk(clk), .rst(rst), .wbWe(wbWe), .rdAddr1(decRs1), .rdAddr2(decRs2),
		.wbAddr(wbAddr), .wbData(wbData), .rdData1(rdData1), .rdData2(rdData2)
	);

	executeUnit i_executeUnit (
		.clk(clk), .rst(rst), .stallAll(stallAll), .exOpcode(exOpcode), .exDst(exDst),
		.exA(exA), .exB(exB), .exStore(exStore), .exPc(exPc), .exWrites(exWrites),
		.branchTaken(branchTaken), .branchTarget(branchTarget),
		.memAddrOrResult(memAddrOrResult), .memStore(memStore), .memOpcode(memOpcode),
		.memDst(memDst), .memWrites(memWrites)
	);

	memoryAccess i_memoryAccess (
		.clk(clk), .rst(rst), .dataDone(dataDone), .memOpcode(memOpcode), .memDst(memDst),
		.memAddrOrResult(memAddrOrResult), .memStore(memStore), .dataRdata(dataRdata),
		.dataReq(dataReq), .dataWe(dataWe), .memBusy(memBusy), .wbWe(wbWe),
		.dataAddr(dataAddr), .dataWdata(dataWdata), .wbData(wbData), .wbAddr(wbAddr)
	);

	pipelineControl i_pipelineControl (
		.decOpcode(decOpcode), .decRs1(decRs1), .decRs2(decRs2), .decRd(decRd),
		.exDst(exDst), .memDst(memDst), .exWrites(exWrites), .memWrites(memWrites),
		.branchTaken(branchTaken), .memBusy(memBusy), .stallFront(stallFront),
		.flushFront(flushFront), .stallAll(stallAll)
	);

endmodule

`default_nettype wire

/* cpuCore_properties.sv */
// Assertions on the core's data port and reset state, bound into the core by the testbench
`timescale 1ns/1ps
`default_nettype none

module cpuCore_properties
	import cpuPkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire wordT instAddr,
	input wire logic dataReq,
	input wire logic dataWe,
	input wire wordT dataAddr,
	input wire wordT dataWdata,
	input wire logic dataDone
);

	// Request level holds its address and data until done
	assert property (@(posedge clk) disable iff (rst)
		dataReq && !dataDone |=> dataReq && $stable(dataAddr) && $stable(dataWdata) &&
		$stable(dataWe))
		else $error("data request changed before done");

	// Request falls in the cycle after done
	assert property (@(posedge clk) disable iff (rst) dataDone |=> !dataReq)
		else $error("data request still high after done");

	assert property (@(posedge clk) disable iff (rst) !$isunknown(instAddr))
		else $error("unknown instruction address");

	// Reset state
	assert property (@(posedge clk) rst |=> instAddr == RESET_PC && !dataReq)
		else $error("wrong state after reset");

endmodule

`default_nettype wire

/* cpuCore_tb.sv */
// Testbench for the pipelined core: runs a fixed program and checks every data access against a model
`timescale 1ns/1ps
`default_nettype none

module cpuCore_tb
	import cpuPkg::*;
();

	localparam int PROG_WORDS = 64;
	localparam int TIMEOUT_CYCLES = 2000;
	localparam logic [31:0] LCG_SEED = 32'h21ea136c;

	logic clk = 1'b0;
	logic rst;
	wordT instAddr;
	wordT instData;
	logic dataReq;
	logic dataWe;
	wordT dataAddr;
	wordT dataWdata;
	logic dataDone;
	wordT dataRdata;

	wordT prog [PROG_WORDS];
	wordT memWords [wordT];
	wordT refMem [wordT];
	wordT refRegs [32];
	wordT refPc;
	bit refHalted;
	bit expWe [$];
	wordT expAddr [$];
	wordT expData [$];
	int accIdx;
	int cycles;
	logic [31:0] lcgState;
	bit waiting;
	int latency;
	int waitCnt;
	int progIdx;

	cpuCore i_cpuCore (
		.clk(clk), .rst(rst), .instAddr(instAddr), .instData(instData),
		.dataReq(dataReq), .dataWe(dataWe), .dataAddr(dataAddr), .dataWdata(dataWdata),
		.dataDone(dataDone), .dataRdata(dataRdata)
	);

	bind cpuCore cpuCore_properties i_cpuCoreProperties (.*);

	always #20 clk = ~clk;

	// Instruction memory returns NOP outside the image
	assign progIdx = int'((instAddr - RESET_PC) >> 2);
	assign instData = (instAddr >= RESET_PC && progIdx < PROG_WORDS) ? prog[progIdx] : NOP_INST;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic wordT fillWord(input wordT a);
		return (a * 32'h9E37_79B1) ^ 32'h5BD1_E995;
	endfunction

	function automatic wordT rType(input opcodeT op, input int rd, input int rs1, input int rs2);
		return {op, rd[4:0], rs1[4:0], rs2[4:0], 10'b0};
	endfunction

	function automatic wordT immForm15(input opcodeT op, input int rd, input int rs1,
		input int imm);
		return {op, rd[4:0], rs1[4:0], imm[14:0]};
	endfunction

	function automatic wordT immForm20(input opcodeT op, input int rd, input int imm);
		return {op, rd[4:0], imm[19:0]};
	endfunction

	// Runs one instruction on the model state and returns 1 when it touched memory
	function automatic bit refStep(output bit we, output wordT addr, output wordT data);
		wordT inst;
		wordT i15;
		wordT i20;
		wordT nextPc;
		logic [4:0] rd;
		logic [4:0] rs1;
		logic [4:0] rs2;
		bit acc;
		int idx;
		idx = int'((refPc - RESET_PC) >> 2);
		inst = (refPc >= RESET_PC && idx < PROG_WORDS) ? prog[idx] : NOP_INST;
		rd = inst[24:20];
		rs1 = inst[19:15];
		rs2 = inst[14:10];
		i15 = {{17{inst[14]}}, inst[14:0]};
		i20 = {{12{inst[19]}}, inst[19:0]};
		nextPc = refPc + 32'd4;
		acc = 1'b0;
		we = 1'b0;
		addr = '0;
		data = '0;
		case (inst[31:25])
			7'h00: refRegs[rd] = refRegs[rs1] + refRegs[rs2];
			7'h01: refRegs[rd] = refRegs[rs1] - refRegs[rs2];
			7'h15: refRegs[rd] = i20;
			7'h11:
			begin
				addr = refRegs[rs1] + i15;
				refRegs[rd] = refMem.exists(addr) ? refMem[addr] : fillWord(addr);
				acc = 1'b1;
			end
			7'h13:
			begin
				addr = refRegs[rs1] + i15;
				data = refRegs[rd];
				refMem[addr] = data;
				we = 1'b1;
				acc = 1'b1;
			end
			7'h30:
			begin
				if (refRegs[rd] == refRegs[rs1])
					nextPc = refPc + i15;
			end
			7'h34:
			begin
				if (refRegs[rd] == '0)
					nextPc = refPc + i20;
			end
			7'h31:
			begin
				nextPc = refRegs[rs1] + i15;
				if (nextPc == refPc)
					refHalted = 1'b1;
			end
			default: ;
		endcase
		refPc = nextPc;
		return acc;
	endfunction

	task automatic fail(input string why);
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "run stopped");
	endtask

	task automatic checkValue(input string name, input wordT expected, input wordT actual);
		if (expected !== actual)
		begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "mismatch");
		end
	endtask

	task automatic loadProgram();
		for (int i = 0; i < PROG_WORDS; i++)
			prog[i] = NOP_INST;
		// Dependent ALU chain into stores
		prog[0] = immForm20(OP_MOVI, 1, 32'h2000);
		prog[1] = immForm20(OP_MOVI, 2, 5);
		prog[2] = immForm20(OP_MOVI, 3, -3);
		prog[3] = rType(OP_ADD, 4, 2, 3);
		prog[4] = rType(OP_SUB, 5, 4, 2);
		prog[5] = rType(OP_ADD, 6, 5, 4);
		prog[6] = immForm15(OP_STW, 6, 1, 0);
		prog[7] = immForm15(OP_STW, 5, 1, 4);
		// Loads of fill data and of a stored word
		prog[8] = immForm15(OP_LDW, 7, 1, 32'h40);
		prog[9] = immForm15(OP_LDW, 8, 1, 32'h44);
		prog[10] = rType(OP_ADD, 9, 7, 8);
		prog[11] = immForm15(OP_STW, 9, 1, 8);
		prog[12] = immForm15(OP_STW, 7, 1, 12);
		prog[13] = immForm15(OP_LDW, 10, 1, 0);
		prog[14] = immForm15(OP_STW, 10, 1, 16);
		// Branches with stores on the wrong path
		prog[15] = immForm15(OP_BEQ, 2, 2, 12);
		prog[16] = immForm15(OP_STW, 2, 1, 32'h100);
		prog[17] = immForm15(OP_STW, 3, 1, 32'h104);
		prog[18] = immForm15(OP_BEQ, 2, 3, 12);
		prog[19] = immForm15(OP_STW, 4, 1, 20);
		prog[20] = immForm20(OP_BZ, 0, 12);
		prog[21] = immForm15(OP_STW, 2, 1, 32'h108);
		prog[22] = immForm15(OP_STW, 2, 1, 32'h10C);
		prog[23] = immForm20(OP_BZ, 2, 12);
		prog[24] = immForm15(OP_STW, 2, 1, 24);
		prog[25] = immForm20(OP_MOVI, 11, 32'h1074);
		prog[26] = immForm15(OP_JUMP, 0, 11, 0);
		prog[27] = immForm15(OP_STW, 3, 1, 32'h110);
		prog[28] = immForm15(OP_STW, 3, 1, 32'h114);
		// Unlisted opcodes between stores
		prog[29] = {7'h05, 5'd4, 20'hABCDE};
		prog[30] = immForm15(OP_STW, 4, 1, 28);
		prog[31] = {7'h40, 5'd9, 20'h12345};
		prog[32] = immForm15(OP_STW, 9, 1, 32);
		prog[33] = immForm20(OP_MOVI, 12, 32'h1088);
		prog[34] = immForm15(OP_JUMP, 0, 12, 0);
	endtask

	task automatic buildExpected();
		bit we;
		wordT a;
		wordT d;
		refPc = RESET_PC;
		refHalted = 1'b0;
		for (int i = 0; i < 32; i++)
			refRegs[i] = '0;
		for (int s = 0; s < 200 && !refHalted; s++)
		begin
			if (refStep(we, a, d))
			begin
				expWe.push_back(we);
				expAddr.push_back(a);
				expData.push_back(d);
			end
		end
		if (!refHalted)
			fail("reference model never reached the final jump");
	endtask

	// Data memory with 0 to 3 cycles of random latency
	always @(negedge clk)
	begin
		if (rst || dataDone)
		begin
			dataDone = 1'b0;
			waiting = 1'b0;
		end
		else if (dataReq)
		begin
			if (!waiting)
			begin
				waiting = 1'b1;
				lcgState = lcgNext(lcgState);
				latency = int'(lcgState[17:16]);
				waitCnt = 0;
			end
			if (waitCnt == latency)
			begin
				if (dataWe)
					memWords[dataAddr] = dataWdata;
				else
					dataRdata = memWords.exists(dataAddr) ? memWords[dataAddr] :
						fillWord(dataAddr);
				dataDone = 1'b1;
			end
			else
				waitCnt++;
		end
	end

	// Compare each completed access with the model sequence
	always @(posedge clk)
	begin
		if (!rst && dataDone)
		begin
			if (accIdx >= expWe.size())
				fail("core made a data access beyond the expected sequence");
			checkValue($sformatf("access %0d we", accIdx), {31'b0, expWe[accIdx]},
				{31'b0, dataWe});
			checkValue($sformatf("access %0d addr", accIdx), expAddr[accIdx], dataAddr);
			if (expWe[accIdx])
				checkValue($sformatf("access %0d wdata", accIdx), expData[accIdx], dataWdata);
			accIdx++;
		end
	end

	always @(posedge clk)
	begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES)
			fail("timeout waiting for the expected data accesses");
	end

	initial
	begin
		rst = 1'b1;
		dataDone = 1'b0;
		dataRdata = '0;
		lcgState = LCG_SEED;
		waiting = 1'b0;
		accIdx = 0;
		cycles = 0;
		loadProgram();
		buildExpected();
		@(posedge clk);
		repeat (8)
		begin
			@(negedge clk);
			checkValue("reset instAddr", RESET_PC, instAddr);
			checkValue("reset dataReq", '0, {31'b0, dataReq});
		end
		rst = 1'b0;
		@(negedge clk);
		checkValue("post-reset dataReq", '0, {31'b0, dataReq});
		while (accIdx < expWe.size())
			@(posedge clk);
		// Idle at the final jump so that any extra access fails the compare
		repeat (40) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
cpuPkg.sv
fetchUnit.sv
instructionDecoder.sv
registerFile.sv
executeUnit.sv
memoryAccess.sv
pipelineControl.sv
cpuCore.sv
cpuCore_properties.sv
cpuCore_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the core testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module cpuCore_tb
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VcpuCore_tb 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^TEST RESULT: PASS$"; then
	exit 0
fi
exit 1
